// ==== source/isa_pkg.sv ====
//////////////////////////////
// ISA widths, register count and functional-unit numbering
//////////////////////////////
package isa_pkg;

    // scalar datapath
    localparam int WORD_W = 32;
    localparam int REG_N  = 32;
    localparam int REG_W  = 5;

    // matrix register index
    localparam int MREG_W = 4;

    // one FUST row per functional unit
    localparam int FU_N = 4;
    localparam int FU_W = 2;

    localparam logic [FU_W-1:0] FU_ALU    = FU_W'(0);
    localparam logic [FU_W-1:0] FU_LDST   = FU_W'(1);
    localparam logic [FU_W-1:0] FU_BRANCH = FU_W'(2);
    localparam logic [FU_W-1:0] FU_GEMM   = FU_W'(3);

    // tag 0 is available, tag k waits on unit k-1
    localparam int TAG_W = 3;

    // saturating age counter
    localparam int AGE_W = 3;

endpackage

// ==== source/datapath_pkg.sv ====
//////////////////////////////
// FUST operand union, row and port structs, row state enum
//////////////////////////////
package datapath_pkg;

    // width of one FUST operand word
    localparam int OP_W = 26;

    typedef logic [isa_pkg::WORD_W-1:0] word_t;
    typedef logic [isa_pkg::REG_W-1:0]  reg_t;
    typedef logic [isa_pkg::MREG_W-1:0] mreg_t;
    typedef logic [isa_pkg::FU_W-1:0]   fu_t;
    typedef logic [isa_pkg::TAG_W-1:0]  tag_t;

    // scalar view keeps t1 and t2 in the low bits
    typedef struct packed {
        logic [OP_W-3*isa_pkg::REG_W-2*isa_pkg::TAG_W-1:0] pad;
        reg_t rd;
        reg_t rs1;
        reg_t rs2;
        tag_t t1;
        tag_t t2;
    } fust_s_t;

    // gemm view puts t3 above the shared t1/t2 bits
    typedef struct packed {
        logic [OP_W-4*isa_pkg::MREG_W-3*isa_pkg::TAG_W-1:0] pad;
        mreg_t md;
        mreg_t ms1;
        mreg_t ms2;
        mreg_t ms3;
        tag_t  t3;
        tag_t  t1;
        tag_t  t2;
    } fust_g_t;

    typedef union packed {
        fust_s_t scalar;
        fust_g_t gemm;
    } fust_op_u;

    typedef struct packed {
        logic     en;
        fu_t      fu;
        fust_op_u op;
    } dispatch_t;

    typedef struct packed {
        logic  en;
        fu_t   fu;
        logic  rw_en;
        reg_t  rd;
        word_t data;
    } wb_t;

    // record handed to execute
    typedef struct packed {
        logic  valid;
        fu_t   fu;
        word_t rdat1;
        word_t rdat2;
        mreg_t ms1;
        mreg_t ms2;
        mreg_t ms3;
    } issue_t;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,
        FUST_RDY,
        FUST_EX
    } fust_state_e;

endpackage

// ==== source/regfile.sv ====
//////////////////////////////
// scalar register file, 2 read ports, write-through
//////////////////////////////
module regfile (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       wen,
    input  logic [isa_pkg::REG_W-1:0]  wsel,
    input  logic [isa_pkg::WORD_W-1:0] wdata,
    input  logic [isa_pkg::REG_W-1:0]  rsel1,
    input  logic [isa_pkg::REG_W-1:0]  rsel2,
    output logic [isa_pkg::WORD_W-1:0] rdat1,
    output logic [isa_pkg::WORD_W-1:0] rdat2
);

    logic [isa_pkg::REG_N-1:0][isa_pkg::WORD_W-1:0] regs;

    // r0 never written so it stays zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    // same-cycle write is forwarded to the readers
    always_comb begin
        if (rsel1 == '0)
            rdat1 = '0;
        else if (wen && wsel == rsel1)
            rdat1 = wdata;
        else
            rdat1 = regs[rsel1];

        if (rsel2 == '0)
            rdat2 = '0;
        else if (wen && wsel == rsel2)
            rdat2 = wdata;
        else
            rdat2 = regs[rsel2];
    end

endmodule

// ==== source/fust_table.sv ====
//////////////////////////////
// FUST row storage, tag wakeup and ready bits
//////////////////////////////
module fust_table (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  datapath_pkg::dispatch_t                         disp,
    input  datapath_pkg::wb_t                               wb,
    output datapath_pkg::fust_op_u [isa_pkg::FU_N-1:0]      rows,
    output logic [isa_pkg::FU_N-1:0]                        rdy
);

    datapath_pkg::tag_t                               wb_tag;
    datapath_pkg::fust_op_u [isa_pkg::FU_N-1:0]       rows_n;

    // clear every tag that names the finishing unit
    function automatic datapath_pkg::fust_op_u wake(
        input datapath_pkg::fust_op_u op,
        input logic                   gemm,
        input logic                   en,
        input datapath_pkg::tag_t     tag
    );
        datapath_pkg::fust_op_u res;
        res = op;
        if (en) begin
            // t1 and t2 line up in both views
            if (op.scalar.t1 == tag)
                res.scalar.t1 = '0;
            if (op.scalar.t2 == tag)
                res.scalar.t2 = '0;
            // only the gemm row carries t3, elsewhere these bits are rs2
            if (gemm && op.gemm.t3 == tag)
                res.gemm.t3 = '0;
        end
        return res;
    endfunction

    // unit k finishing wakes tag k+1
    assign wb_tag = isa_pkg::TAG_W'(wb.fu) + isa_pkg::TAG_W'(1);

    always_comb begin
        for (int i = 0; i < isa_pkg::FU_N; i++) begin
            rows_n[i] = wake((disp.en && disp.fu == isa_pkg::FU_W'(i)) ? disp.op : rows[i],
                             isa_pkg::FU_W'(i) == isa_pkg::FU_GEMM,
                             wb.en,
                             wb_tag);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            rows <= '0;
        else
            rows <= rows_n;
    end

    // ready once no operand tag is pending
    always_comb begin
        for (int i = 0; i < isa_pkg::FU_N; i++) begin
            rdy[i] = (rows[i].scalar.t1 == '0) && (rows[i].scalar.t2 == '0);
            if (isa_pkg::FU_W'(i) == isa_pkg::FU_GEMM)
                rdy[i] = rdy[i] && (rows[i].gemm.t3 == '0);
        end
    end

endmodule

// ==== source/fust_age.sv ====
//////////////////////////////
// per-row age counters and oldest-ready grant
//////////////////////////////
module fust_age (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  datapath_pkg::dispatch_t                       disp,
    input  datapath_pkg::fust_state_e [isa_pkg::FU_N-1:0] state,
    input  logic                                          freeze,
    output logic [isa_pkg::FU_N-1:0]                      grant
);

    logic [isa_pkg::FU_N-1:0][isa_pkg::AGE_W-1:0] age;
    logic [isa_pkg::FU_N-1:0][isa_pkg::AGE_W-1:0] age_n;
    logic [isa_pkg::AGE_W-1:0]                    best_age;
    logic                                         found;

    always_comb begin
        for (int i = 0; i < isa_pkg::FU_N; i++) begin
            if (disp.en && disp.fu == isa_pkg::FU_W'(i)) begin
                age_n[i] = isa_pkg::AGE_W'(1);
            end else begin
                case (state[i])
                    datapath_pkg::FUST_WAIT,
                    datapath_pkg::FUST_RDY: begin
                        // saturate at the top count
                        age_n[i] = (&age[i]) ? age[i] : age[i] + isa_pkg::AGE_W'(1);
                    end
                    default: age_n[i] = '0;
                endcase
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            age <= '0;
        else
            age <= age_n;
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        grant    = '0;
        best_age = '0;
        found    = 1'b0;
        for (int i = 0; i < isa_pkg::FU_N; i++) begin
            if (state[i] == datapath_pkg::FUST_RDY && (!found || age[i] > best_age)) begin
                found    = 1'b1;
                best_age = age[i];
                grant    = '0;
                grant[i] = 1'b1;
            end
        end
        // nothing issues while frozen
        if (freeze)
            grant = '0;
    end

endmodule

// ==== source/fust_state_ctrl.sv ====
//////////////////////////////
// per-row FSM EMPTY/WAIT/RDY/EX and busy bits
//////////////////////////////
module fust_state_ctrl (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  datapath_pkg::dispatch_t                       disp,
    input  datapath_pkg::wb_t                             wb,
    input  logic [isa_pkg::FU_N-1:0]                      rdy,
    input  logic [isa_pkg::FU_N-1:0]                      grant,
    output datapath_pkg::fust_state_e [isa_pkg::FU_N-1:0] state,
    output logic [isa_pkg::FU_N-1:0]                      busy
);

    datapath_pkg::fust_state_e [isa_pkg::FU_N-1:0] state_n;
    logic [isa_pkg::FU_N-1:0]                      disp_hit;
    logic [isa_pkg::FU_N-1:0]                      wb_hit;

    // decode the dispatch and writeback targets
    always_comb begin
        for (int i = 0; i < isa_pkg::FU_N; i++) begin
            disp_hit[i] = disp.en && disp.fu == isa_pkg::FU_W'(i);
            wb_hit[i]   = wb.en && wb.fu == isa_pkg::FU_W'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < isa_pkg::FU_N; i++) begin
            state_n[i] = state[i];
            case (state[i])
                datapath_pkg::FUST_EMPTY: begin
                    if (disp_hit[i])
                        state_n[i] = datapath_pkg::FUST_WAIT;
                end
                datapath_pkg::FUST_WAIT: begin
                    // operands may still be pending
                    if (rdy[i])
                        state_n[i] = datapath_pkg::FUST_RDY;
                end
                datapath_pkg::FUST_RDY: begin
                    if (grant[i])
                        state_n[i] = datapath_pkg::FUST_EX;
                end
                datapath_pkg::FUST_EX: begin
                    // unit done so the row is free for the next dispatch
                    if (wb_hit[i])
                        state_n[i] = datapath_pkg::FUST_EMPTY;
                end
                default: state_n[i] = datapath_pkg::FUST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < isa_pkg::FU_N; i++)
                state[i] <= datapath_pkg::FUST_EMPTY;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        for (int i = 0; i < isa_pkg::FU_N; i++)
            busy[i] = state[i] != datapath_pkg::FUST_EMPTY;
    end

endmodule

// ==== source/issue.sv ====
//////////////////////////////
// issue stage top, register read and issue record
//////////////////////////////
module issue (
    input  logic                     CLK,
    input  logic                     nRST,
    input  datapath_pkg::dispatch_t  disp,
    input  datapath_pkg::wb_t        wb,
    input  logic                     freeze,
    output datapath_pkg::issue_t     out,
    output logic [isa_pkg::FU_N-1:0] fust_busy
);

    datapath_pkg::fust_op_u [isa_pkg::FU_N-1:0]    rows;
    datapath_pkg::fust_state_e [isa_pkg::FU_N-1:0] state;
    logic [isa_pkg::FU_N-1:0]                      rdy;
    logic [isa_pkg::FU_N-1:0]                      grant;
    datapath_pkg::fu_t                             sel_fu;
    datapath_pkg::fust_op_u                        sel_op;
    logic                                          sel_gemm;
    datapath_pkg::reg_t                            rs1;
    datapath_pkg::reg_t                            rs2;
    datapath_pkg::word_t                           rdat1;
    datapath_pkg::word_t                           rdat2;
    datapath_pkg::issue_t                          out_n;

    regfile rf (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb.en && wb.rw_en),
        .wsel  (wb.rd),
        .wdata (wb.data),
        .rsel1 (rs1),
        .rsel2 (rs2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    fust_table table_u (
        .CLK  (CLK),
        .nRST (nRST),
        .disp (disp),
        .wb   (wb),
        .rows (rows),
        .rdy  (rdy)
    );

    fust_age age_u (
        .CLK    (CLK),
        .nRST   (nRST),
        .disp   (disp),
        .state  (state),
        .freeze (freeze),
        .grant  (grant)
    );

    fust_state_ctrl ctrl_u (
        .CLK   (CLK),
        .nRST  (nRST),
        .disp  (disp),
        .wb    (wb),
        .rdy   (rdy),
        .grant (grant),
        .state (state),
        .busy  (fust_busy)
    );

    // one-hot grant to row index
    always_comb begin
        sel_fu = '0;
        for (int i = 0; i < isa_pkg::FU_N; i++) begin
            if (grant[i])
                sel_fu = isa_pkg::FU_W'(i);
        end
    end

    assign sel_op   = rows[sel_fu];
    assign sel_gemm = sel_fu == isa_pkg::FU_GEMM;

    // gemm row has no scalar sources to read
    assign rs1 = sel_gemm ? '0 : sel_op.scalar.rs1;
    assign rs2 = sel_gemm ? '0 : sel_op.scalar.rs2;

    always_comb begin
        out_n = '0;
        if (|grant) begin
            out_n.valid = 1'b1;
            out_n.fu    = sel_fu;
            if (sel_gemm) begin
                out_n.ms1 = sel_op.gemm.ms1;
                out_n.ms2 = sel_op.gemm.ms2;
                out_n.ms3 = sel_op.gemm.ms3;
            end else begin
                out_n.rdat1 = rdat1;
                out_n.rdat2 = rdat2;
            end
        end
    end

    // freeze holds the record for execute
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            out <= '0;
        else if (!freeze)
            out <= out_n;
    end

endmodule

// ==== bench/issue_checker.sv ====
//////////////////////////////
// bound assertions on issue stage internals
//////////////////////////////
module issue_checker (
    input logic                                          CLK,
    input logic                                          nRST,
    input datapath_pkg::dispatch_t                       disp,
    input logic                                          freeze,
    input datapath_pkg::issue_t                          out,
    input logic [isa_pkg::FU_N-1:0]                      fust_busy,
    input logic [isa_pkg::FU_N-1:0]                      grant,
    input datapath_pkg::fust_state_e [isa_pkg::FU_N-1:0] state
);
    timeunit 1ns;
    timeprecision 100ps;

    a_grant_onehot: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(grant))
        else $error("grant selects more than one row: %b", grant);

    // execute keeps the same record while frozen
    a_freeze_hold: assert property (@(posedge CLK) disable iff (!nRST) freeze |=> $stable(out))
        else $error("issue record changed while freeze was high");

    a_disp_free: assert property (@(posedge CLK) disable iff (!nRST)
        disp.en |-> !fust_busy[disp.fu])
        else $error("dispatch targeted busy row %0d", disp.fu);

    for (genvar i = 0; i < isa_pkg::FU_N; i++) begin : g_ex
        // EX is reachable from RDY only
        a_ex_from_rdy: assert property (@(posedge CLK) disable iff (!nRST)
            (state[i] != datapath_pkg::FUST_RDY && state[i] != datapath_pkg::FUST_EX)
            |=> state[i] != datapath_pkg::FUST_EX)
            else $error("row %0d entered EX without being ready", i);
    end

endmodule

// ==== bench/tb_issue.sv ====
//////////////////////////////
// issue stage testbench, pattern-driven stimulus and checks
//////////////////////////////
module tb_issue;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_MAX = 40;

    logic                     CLK = 1'b0;
    logic                     nRST;
    datapath_pkg::dispatch_t  disp;
    datapath_pkg::wb_t        wb;
    logic                     freeze;
    datapath_pkg::issue_t     issue_out;
    logic [isa_pkg::FU_N-1:0] busy;

    int    checks;
    int    errors;
    int    timeouts;
    logic  abort;
    string test_name;

    issue uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .disp      (disp),
        .wb        (wb),
        .freeze    (freeze),
        .out       (issue_out),
        .fust_busy (busy)
    );

    bind issue issue_checker chk (
        .CLK       (CLK),
        .nRST      (nRST),
        .disp      (disp),
        .freeze    (freeze),
        .out       (out),
        .fust_busy (fust_busy),
        .grant     (grant),
        .state     (state)
    );

    initial begin
        forever #50 CLK = ~CLK;
    end

    function automatic string strip_eol(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r[r.len()-1] == "\n" || r[r.len()-1] == "\r"))
            r = r.substr(0, r.len() - 2);
        return r;
    endfunction

    // strobes last one cycle, starting and ending on a falling edge
    task automatic send_dispatch(input datapath_pkg::fu_t fu, input datapath_pkg::fust_op_u op);
        disp.en = 1'b1;
        disp.fu = fu;
        disp.op = op;
        @(negedge CLK);
        disp = '0;
    endtask

    task automatic send_writeback(input logic [31:0] fu, rw_en, rd, data);
        wb.en    = 1'b1;
        wb.fu    = fu[isa_pkg::FU_W-1:0];
        wb.rw_en = rw_en[0];
        wb.rd    = rd[isa_pkg::REG_W-1:0];
        wb.data  = data;
        @(negedge CLK);
        wb = '0;
    endtask

    // lat counts falling edges until the record shows up and 0 accepts any
    task automatic check_record(input datapath_pkg::issue_t exp, input int lat);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WAIT_MAX) begin
            @(negedge CLK);
            waited++;
            seen = issue_out.valid && issue_out.fu == exp.fu;
        end
        if (!seen) begin
            $display("no issue record from row %0d arrived within %0d cycles in test %s",
                     exp.fu, WAIT_MAX, test_name);
            timeouts++;
            abort = 1'b1;
        end else begin
            checks++;
            assert (issue_out == exp) else begin
                $display("FAIL %s record: expected fu=%0d rdat1=%h rdat2=%h ms=%h/%h/%h",
                         test_name, exp.fu, exp.rdat1, exp.rdat2, exp.ms1, exp.ms2, exp.ms3);
                $display("FAIL %s record: actual fu=%0d rdat1=%h rdat2=%h ms=%h/%h/%h",
                         test_name, issue_out.fu, issue_out.rdat1, issue_out.rdat2,
                         issue_out.ms1, issue_out.ms2, issue_out.ms3);
                errors++;
            end
            if (lat != 0) begin
                checks++;
                assert (waited == lat) else begin
                    $display("FAIL %s latency: expected %0d actual %0d", test_name, lat, waited);
                    errors++;
                end
            end
        end
    endtask

    task automatic check_hold(input int cycles);
        datapath_pkg::issue_t held;
        held = issue_out;
        for (int i = 0; i < cycles; i++) begin
            @(negedge CLK);
            checks++;
            assert (issue_out == held) else begin
                $display("FAIL %s hold: expected %h actual %h", test_name, held, issue_out);
                errors++;
            end
        end
    endtask

    task automatic check_busy(input logic [isa_pkg::FU_N-1:0] exp);
        checks++;
        assert (busy == exp) else begin
            $display("FAIL %s fust_busy: expected %b actual %b", test_name, exp, busy);
            errors++;
        end
    endtask

    initial begin
        int                     fd;
        int                     code;
        string                  line;
        byte                    cmd;
        logic [31:0]            v0, v1, v2, v3, v4, v5, v6;
        datapath_pkg::fust_op_u op;
        datapath_pkg::issue_t   exp;

        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        abort     = 1'b0;
        test_name = "reset";
        disp      = '0;
        wb        = '0;
        freeze    = 1'b0;
        nRST      = 1'b0;
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        checks++;
        assert (!issue_out.valid) else begin
            $display("FAIL reset out.valid: expected 0 actual %b", issue_out.valid);
            errors++;
        end

        fd = $fopen("bench/issue_patterns.txt", "r");
        if (fd == 0) begin
            $display("the pattern file bench/issue_patterns.txt could not be opened");
            errors++;
        end else begin
            while (!abort && !$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                cmd  = (line.len() > 0) ? line[0] : "#";
                line = (line.len() > 2) ? strip_eol(line.substr(2, line.len() - 1)) : "";
                case (cmd)
                    "T": test_name = line;
                    "D": begin
                        code = $sscanf(line, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
                        op            = '0;
                        op.scalar.rd  = v1[isa_pkg::REG_W-1:0];
                        op.scalar.rs1 = v2[isa_pkg::REG_W-1:0];
                        op.scalar.rs2 = v3[isa_pkg::REG_W-1:0];
                        op.scalar.t1  = v4[isa_pkg::TAG_W-1:0];
                        op.scalar.t2  = v5[isa_pkg::TAG_W-1:0];
                        send_dispatch(v0[isa_pkg::FU_W-1:0], op);
                    end
                    "G": begin
                        code = $sscanf(line, "%h %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5, v6);
                        op          = '0;
                        op.gemm.md  = v0[isa_pkg::MREG_W-1:0];
                        op.gemm.ms1 = v1[isa_pkg::MREG_W-1:0];
                        op.gemm.ms2 = v2[isa_pkg::MREG_W-1:0];
                        op.gemm.ms3 = v3[isa_pkg::MREG_W-1:0];
                        op.gemm.t1  = v4[isa_pkg::TAG_W-1:0];
                        op.gemm.t2  = v5[isa_pkg::TAG_W-1:0];
                        op.gemm.t3  = v6[isa_pkg::TAG_W-1:0];
                        send_dispatch(isa_pkg::FU_GEMM, op);
                    end
                    "W": begin
                        code = $sscanf(line, "%h %h %h %h", v0, v1, v2, v3);
                        send_writeback(v0, v1, v2, v3);
                    end
                    "F": begin
                        code   = $sscanf(line, "%h", v0);
                        freeze = v0[0];
                    end
                    "I": begin
                        code = $sscanf(line, "%h", v0);
                        repeat (v0) @(negedge CLK);
                    end
                    "H": begin
                        code = $sscanf(line, "%h", v0);
                        check_hold(int'(v0));
                    end
                    "B": begin
                        code = $sscanf(line, "%h", v0);
                        check_busy(v0[isa_pkg::FU_N-1:0]);
                    end
                    "E": begin
                        code = $sscanf(line, "%h %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5, v6);
                        exp       = '0;
                        exp.valid = 1'b1;
                        exp.fu    = v0[isa_pkg::FU_W-1:0];
                        exp.rdat1 = v1;
                        exp.rdat2 = v2;
                        exp.ms1   = v3[isa_pkg::MREG_W-1:0];
                        exp.ms2   = v4[isa_pkg::MREG_W-1:0];
                        exp.ms3   = v5[isa_pkg::MREG_W-1:0];
                        check_record(exp, int'(v6));
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
source/isa_pkg.sv
source/datapath_pkg.sv
source/regfile.sv
source/fust_table.sv
source/fust_age.sv
source/fust_state_ctrl.sv
source/issue.sv
bench/issue_checker.sv
bench/tb_issue.sv

// ==== run.sh ====
#!/bin/sh
# build the issue stage testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_issue -Mdir obj_dir -o tb_issue_sim -f src.f

./obj_dir/tb_issue_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// ==== bench/issue_patterns.txt ====
# T name | D fu rd rs1 rs2 t1 t2 | G md ms1 ms2 ms3 t1 t2 t3 | W fu rw_en rd data | F level
# I cycles | H cycles | B busy | E fu rdat1 rdat2 ms1 ms2 ms3 lat (lat 0 = any), fields in hex
T reset
B 0
T wb_then_alu
W 3 1 05 cafe0005
D 0 01 05 00 0 0
E 0 cafe0005 00000000 0 0 0 2
B 1
W 0 0 00 00000000
B 0
T tag_wakeup
D 0 02 05 00 0 0
E 0 cafe0005 00000000 0 0 0 2
D 1 03 02 05 1 0
H 5
B 3
W 0 1 02 12345678
E 1 12345678 cafe0005 0 0 0 2
W 1 0 00 00000000
T oldest_first
D 2 00 05 02 2 0
I 2
D 0 04 02 00 2 0
I 1
W 1 0 00 00000000
E 2 cafe0005 12345678 0 0 0 2
E 0 12345678 00000000 0 0 0 1
W 2 0 00 00000000
W 0 0 00 00000000
B 0
T gemm_decode
G 1 a b c 1 2 3
W 0 0 00 00000000
H 3
W 1 0 00 00000000
H 3
W 2 0 00 00000000
E 3 00000000 00000000 a b c 2
W 3 0 00 00000000
T freeze_hold
D 0 01 05 02 0 0
E 0 cafe0005 12345678 0 0 0 2
F 1
D 1 03 02 00 0 0
H 6
B 3
F 0
E 1 12345678 00000000 0 0 0 1
W 0 0 00 00000000
W 1 0 00 00000000
B 0
